// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // ====================================================================
  // fixed cache geometry
  // ====================================================================
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned IDX_W      = 4;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned OFS_W      = 4;
  localparam int unsigned TAG_W      = ADDR_W - IDX_W - OFS_W;

  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  // fetch view for lookups and hit-invalidate, index view for index-invalidate
  typedef union packed {
    struct packed {
      logic [TAG_W-1:0]              tag;
      logic [IDX_W-1:0]              idx;
      logic [$clog2(LINE_WORDS)-1:0] word;
      logic [1:0]                    byte_ofs;
    } fetch;
    struct packed {
      logic [ADDR_W-IDX_W-OFS_W-1:0] unused;
      logic [IDX_W-1:0]              idx;
      logic [OFS_W-1:0]              way;
    } index;
  } icache_addr_u;

  typedef enum logic {
    CACOP_IDX_INV = 1'b0,
    CACOP_HIT_INV = 1'b1
  } cacop_op_e;

  // register map of the control block
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_HIT_CNT  = 2'd1,
    REG_MISS_CNT = 2'd2
  } reg_addr_e;

endpackage

`default_nettype wire

// ==== src/icache_sdp_ram.sv ====
`default_nettype none

module icache_sdp_ram #(
  parameter int unsigned DEPTH = 16,
  parameter int unsigned WIDTH = 32
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     we_i,
  input  wire logic [$clog2(DEPTH)-1:0] waddr_i,
  input  wire logic [WIDTH-1:0]         wdata_i,
  input  wire logic [$clog2(DEPTH)-1:0] raddr_i,
  output logic      [WIDTH-1:0]         rdata_o
);

  logic [WIDTH-1:0] mem [DEPTH];
  // entries never written since reset read as zero
  logic [DEPTH-1:0] written_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      written_q <= '0;
      rdata_o   <= '0;
    end else begin
      if (we_i) begin
        written_q[waddr_i] <= 1'b1;
      end
      // write-first on an address collision
      if (we_i && waddr_i == raddr_i) begin
        rdata_o <= wdata_i;
      end else if (written_q[raddr_i]) begin
        rdata_o <= mem[raddr_i];
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_plru.sv ====
`default_nettype none

module icache_plru #(
  parameter int unsigned WAY_NUM = 4
) (
  input  wire logic [WAY_NUM-2:0]         state_i,
  input  wire logic                       hit_i,
  input  wire logic [$clog2(WAY_NUM)-1:0] hit_way_i,
  output logic      [$clog2(WAY_NUM)-1:0] victim_o,
  output logic      [WAY_NUM-2:0]         state_o
);

  localparam int unsigned LVL = $clog2(WAY_NUM);

  logic [LVL-1:0] used_way;

  // heap numbering, node n has children 2n and 2n+1, bit n-1 points to the victim side
  always_comb begin
    int unsigned node;
    node = 1;
    for (int l = LVL - 1; l >= 0; l--) begin
      victim_o[l] = state_i[node-1];
      node = 2 * node + int'(state_i[node-1]);
    end
  end

  assign used_way = hit_i ? hit_way_i : victim_o;

  // turn every node on the used path away from it
  always_comb begin
    int unsigned node;
    state_o = state_i;
    node = 1;
    for (int l = LVL - 1; l >= 0; l--) begin
      state_o[node-1] = ~used_way[l];
      node = 2 * node + int'(used_way[l]);
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_core.sv ====
`default_nettype none

module icache_core #(
  parameter int unsigned WAY_NUM = 4
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              flush_i,
  input  wire logic                              fetch_valid_i,
  input  wire logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
  output logic                                   fetch_ready_o,
  output logic                                   rsp_valid_o,
  output logic      [icache_pkg::WORD_W-1:0]     rsp_instr_o,
  input  wire logic                              rsp_ready_i,
  input  wire logic                              cacop_valid_i,
  input  wire icache_pkg::cacop_op_e             cacop_op_i,
  input  wire logic [icache_pkg::ADDR_W-1:0]     cacop_addr_i,
  output logic                                   cacop_ready_o,
  output logic                                   cacop_done_o,
  output logic                                   mem_ar_valid_o,
  output logic      [icache_pkg::ADDR_W-1:0]     mem_ar_addr_o,
  output logic      [7:0]                        mem_ar_len_o,
  input  wire logic                              mem_ar_ready_i,
  input  wire logic                              mem_r_valid_i,
  input  wire logic [icache_pkg::WORD_W-1:0]     mem_r_data_i,
  input  wire logic                              mem_r_last_i,
  output logic                                   mem_r_ready_o,
  input  wire logic                              cache_en_i,
  output logic                                   hit_pulse_o,
  output logic                                   miss_pulse_o
);

  localparam int unsigned WAY_W  = $clog2(WAY_NUM);
  localparam int unsigned BEAT_W = $clog2(icache_pkg::LINE_WORDS);
  localparam int unsigned SETS   = 2 ** icache_pkg::IDX_W;

  localparam logic [1:0] S_IDLE     = 2'd0;
  localparam logic [1:0] S_REQ      = 2'd1;
  localparam logic [1:0] S_REFILL   = 2'd2;
  localparam logic [1:0] S_UNCACHED = 2'd3;

  logic [1:0]                     state_q;
  logic                           init_q;
  logic                           s1_ready, accept_fetch, accept_cacop;
  logic                           s1_fetch_v, s1_cacop_v, s1_uncached;
  icache_pkg::cacop_op_e          s1_op;
  icache_pkg::icache_addr_u       s0_addr, s1_addr;
  logic [icache_pkg::IDX_W-1:0]   ram_raddr;
  icache_pkg::line_t              data_rd [WAY_NUM];
  logic [icache_pkg::TAG_W-1:0]   tag_rd [WAY_NUM];
  logic [WAY_NUM-1:0]             valid_rd, valid_we, fill_way_we, hit_oh;
  logic [WAY_NUM-2:0]             plru_rd, plru_wd;
  logic                           plru_we, hit, lookup_hit, hit_take, fill_we;
  logic [WAY_W-1:0]               hit_way, victim;
  logic [BEAT_W-1:0]              beat_q;
  icache_pkg::line_t              line_buf, fill_line;

  // ====================================================================
  // stage 0, request accept and RAM indexing
  // ====================================================================
  assign s1_ready = (state_q == S_IDLE || state_q == S_UNCACHED) &&
                    (!s1_fetch_v || (rsp_valid_o && rsp_ready_i));
  // cacop wins over a same-cycle fetch
  assign cacop_ready_o = init_q & s1_ready;
  assign fetch_ready_o = init_q & s1_ready & ~cacop_valid_i & ~flush_i;
  assign accept_cacop  = cacop_valid_i & cacop_ready_o;
  assign accept_fetch  = fetch_valid_i & fetch_ready_o;
  assign s0_addr       = cacop_valid_i ? cacop_addr_i : fetch_addr_i;
  // held item re-reads its own set
  assign ram_raddr     = s1_ready ? s0_addr.fetch.idx : s1_addr.fetch.idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q     <= 1'b0;
      s1_fetch_v <= 1'b0;
      s1_cacop_v <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (s1_ready) begin
        s1_fetch_v <= accept_fetch;
        s1_cacop_v <= accept_cacop;
      end
      if (flush_i) begin
        s1_fetch_v <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_addr     <= s0_addr;
      s1_op       <= cacop_op_i;
      s1_uncached <= ~cache_en_i;
    end
  end

  // ====================================================================
  // stage 1, tag compare and response
  // ====================================================================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      hit_oh[w] = valid_rd[w] && (tag_rd[w] == s1_addr.fetch.tag);
      if (hit_oh[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end
  assign hit = |hit_oh;

  assign lookup_hit   = s1_fetch_v & ~s1_uncached & hit & (state_q == S_IDLE);
  assign hit_take     = lookup_hit & rsp_ready_i;
  assign rsp_valid_o  = lookup_hit | (s1_fetch_v & (state_q == S_UNCACHED));
  // after a burst the word comes from the line buffer
  assign rsp_instr_o  = (state_q == S_UNCACHED) ?
                        line_buf[s1_uncached ? '0 : s1_addr.fetch.word] :
                        data_rd[hit_way][s1_addr.fetch.word];
  assign hit_pulse_o  = hit_take;
  assign miss_pulse_o = s1_fetch_v & ~s1_uncached & ~hit & (state_q == S_IDLE) & ~flush_i;
  assign cacop_done_o = s1_cacop_v;

  // ====================================================================
  // refill FSM and burst read port
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (s1_fetch_v && (s1_uncached || !hit) && !flush_i) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (mem_ar_ready_i) begin
            state_q <= S_REFILL;
          end
        end
        S_REFILL: begin
          // a flushed fetch drains its burst and returns to idle
          if (mem_r_valid_i && mem_r_last_i) begin
            state_q <= (s1_fetch_v && !flush_i) ? S_UNCACHED : S_IDLE;
          end
        end
        default: begin
          if (!s1_fetch_v || rsp_ready_i) begin
            state_q <= S_IDLE;
          end
        end
      endcase
      if (state_q == S_REFILL) begin
        if (mem_r_valid_i) begin
          beat_q <= beat_q + 1'b1;
        end
      end else begin
        beat_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_REFILL && mem_r_valid_i) begin
      line_buf[beat_q] <= mem_r_data_i;
    end
  end

  assign mem_ar_valid_o = (state_q == S_REQ);
  assign mem_ar_addr_o  = s1_uncached ?
                          {s1_addr.fetch.tag, s1_addr.fetch.idx, s1_addr.fetch.word, 2'b00} :
                          {s1_addr.fetch.tag, s1_addr.fetch.idx, {icache_pkg::OFS_W{1'b0}}};
  assign mem_ar_len_o   = s1_uncached ? 8'd0 : 8'(icache_pkg::LINE_WORDS - 1);
  assign mem_r_ready_o  = (state_q == S_REFILL);

  // ====================================================================
  // RAM write control
  // ====================================================================
  always_comb begin
    for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
      fill_line[i] = (beat_q == BEAT_W'(i)) ? mem_r_data_i : line_buf[i];
    end
  end

  assign fill_we = (state_q == S_REFILL) & mem_r_valid_i & mem_r_last_i &
                   s1_fetch_v & ~s1_uncached & ~flush_i;

  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      fill_way_we[w] = fill_we && (victim == WAY_W'(w));
      if (s1_op == icache_pkg::CACOP_IDX_INV) begin
        valid_we[w] = fill_way_we[w] ||
                      (s1_cacop_v && s1_addr.index.way[WAY_W-1:0] == WAY_W'(w));
      end else begin
        valid_we[w] = fill_way_we[w] || (s1_cacop_v && hit_oh[w]);
      end
    end
  end

  assign plru_we = hit_take | fill_we;

  icache_plru #(
    .WAY_NUM (WAY_NUM)
  ) u_plru (
    .state_i   (plru_rd),
    .hit_i     (state_q == S_IDLE),
    .hit_way_i (hit_way),
    .victim_o  (victim),
    .state_o   (plru_wd)
  );

  for (genvar w = 0; w < WAY_NUM; w++) begin : gen_way
    icache_sdp_ram #(
      .DEPTH (SETS),
      .WIDTH ($bits(icache_pkg::line_t))
    ) u_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (fill_way_we[w]),
      .waddr_i (s1_addr.fetch.idx),
      .wdata_i (fill_line),
      .raddr_i (ram_raddr),
      .rdata_o (data_rd[w])
    );

    icache_sdp_ram #(
      .DEPTH (SETS),
      .WIDTH (icache_pkg::TAG_W)
    ) u_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (fill_way_we[w]),
      .waddr_i (s1_addr.fetch.idx),
      .wdata_i (s1_addr.fetch.tag),
      .raddr_i (ram_raddr),
      .rdata_o (tag_rd[w])
    );

    icache_sdp_ram #(
      .DEPTH (SETS),
      .WIDTH (1)
    ) u_valid_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (valid_we[w]),
      .waddr_i (s1_addr.fetch.idx),
      .wdata_i (~s1_cacop_v),
      .raddr_i (ram_raddr),
      .rdata_o (valid_rd[w])
    );
  end

  icache_sdp_ram #(
    .DEPTH (SETS),
    .WIDTH (WAY_NUM - 1)
  ) u_plru_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (plru_we),
    .waddr_i (s1_addr.fetch.idx),
    .wdata_i (plru_wd),
    .raddr_i (ram_raddr),
    .rdata_o (plru_rd)
  );

endmodule

`default_nettype wire

// ==== src/icache_ctrl_regs.sv ====
`default_nettype none

module icache_ctrl_regs (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  cfg_req_i,
  input  wire logic                  cfg_we_i,
  input  wire icache_pkg::reg_addr_e cfg_addr_i,
  input  wire logic [31:0]           cfg_wdata_i,
  output logic                       cfg_ack_o,
  output logic      [31:0]           cfg_rdata_o,
  input  wire logic                  hit_pulse_i,
  input  wire logic                  miss_pulse_i,
  output logic                       cache_en_o
);

  logic [31:0] hit_cnt_q, miss_cnt_q;
  logic        access, hit_clr, miss_clr;

  // ack low is the idle state, ack high waits for req to drop
  assign access   = cfg_req_i & ~cfg_ack_o;
  assign hit_clr  = access & cfg_we_i & (cfg_addr_i == icache_pkg::REG_HIT_CNT);
  assign miss_clr = access & cfg_we_i & (cfg_addr_i == icache_pkg::REG_MISS_CNT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack_o  <= 1'b0;
      cache_en_o <= 1'b1;
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end else begin
      if (access) begin
        cfg_ack_o <= 1'b1;
      end else if (cfg_ack_o && !cfg_req_i) begin
        cfg_ack_o <= 1'b0;
      end
      if (access && cfg_we_i && cfg_addr_i == icache_pkg::REG_CTRL) begin
        cache_en_o <= cfg_wdata_i[0];
      end
      // saturating counters, a write clears
      if (hit_clr) begin
        hit_cnt_q <= '0;
      end else if (hit_pulse_i && hit_cnt_q != '1) begin
        hit_cnt_q <= hit_cnt_q + 1'b1;
      end
      if (miss_clr) begin
        miss_cnt_q <= '0;
      end else if (miss_pulse_i && miss_cnt_q != '1) begin
        miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
  end

  // read data captured with the access, stable while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      case (cfg_addr_i)
        icache_pkg::REG_CTRL:     cfg_rdata_o <= {31'b0, cache_en_o};
        icache_pkg::REG_HIT_CNT:  cfg_rdata_o <= hit_cnt_q;
        icache_pkg::REG_MISS_CNT: cfg_rdata_o <= miss_cnt_q;
        default:                  cfg_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_top.sv ====
`default_nettype none

module icache_top #(
  parameter int unsigned WAY_NUM = 4
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          flush_i,
  input  wire logic                          fetch_valid_i,
  input  wire logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                               fetch_ready_o,
  output logic                               rsp_valid_o,
  output logic      [icache_pkg::WORD_W-1:0] rsp_instr_o,
  input  wire logic                          rsp_ready_i,
  input  wire logic                          cacop_valid_i,
  input  wire icache_pkg::cacop_op_e         cacop_op_i,
  input  wire logic [icache_pkg::ADDR_W-1:0] cacop_addr_i,
  output logic                               cacop_ready_o,
  output logic                               cacop_done_o,
  output logic                               mem_ar_valid_o,
  output logic      [icache_pkg::ADDR_W-1:0] mem_ar_addr_o,
  output logic      [7:0]                    mem_ar_len_o,
  input  wire logic                          mem_ar_ready_i,
  input  wire logic                          mem_r_valid_i,
  input  wire logic [icache_pkg::WORD_W-1:0] mem_r_data_i,
  input  wire logic                          mem_r_last_i,
  output logic                               mem_r_ready_o,
  input  wire logic                          cfg_req_i,
  input  wire logic                          cfg_we_i,
  input  wire icache_pkg::reg_addr_e         cfg_addr_i,
  input  wire logic [31:0]                   cfg_wdata_i,
  output logic                               cfg_ack_o,
  output logic      [31:0]                   cfg_rdata_o
);

  logic cache_en, hit_pulse, miss_pulse;

  icache_core #(
    .WAY_NUM (WAY_NUM)
  ) u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_instr_o    (rsp_instr_o),
    .rsp_ready_i    (rsp_ready_i),
    .cacop_valid_i  (cacop_valid_i),
    .cacop_op_i     (cacop_op_i),
    .cacop_addr_i   (cacop_addr_i),
    .cacop_ready_o  (cacop_ready_o),
    .cacop_done_o   (cacop_done_o),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_ar_len_o   (mem_ar_len_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_last_i   (mem_r_last_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .cache_en_i     (cache_en),
    .hit_pulse_o    (hit_pulse),
    .miss_pulse_o   (miss_pulse)
  );

  icache_ctrl_regs u_ctrl_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_req_i    (cfg_req_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_ack_o    (cfg_ack_o),
    .cfg_rdata_o  (cfg_rdata_o),
    .hit_pulse_i  (hit_pulse),
    .miss_pulse_i (miss_pulse),
    .cache_en_o   (cache_en)
  );

endmodule

`default_nettype wire

// ==== tb/tb_mem_model.sv ====
`default_nettype none

module tb_mem_model (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        ar_valid_i,
  input  wire logic [31:0] ar_addr_i,
  input  wire logic [7:0]  ar_len_i,
  output logic             ar_ready_o,
  output logic             r_valid_o,
  output logic [31:0]      r_data_o,
  output logic             r_last_o
);

  logic [31:0] base;
  logic [7:0]  len;

  // every word is its own address xor a fixed pattern
  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && ar_valid_i) begin
        base = ar_addr_i;
        len  = ar_len_i;
        // two cycles before the address is taken
        repeat (2) @(posedge clk);
        #2 ar_ready_o = 1'b1;
        @(posedge clk);
        #2 ar_ready_o = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
          @(posedge clk);
          #2;
          r_valid_o = 1'b1;
          r_data_o  = (base + 32'(4 * b)) ^ 32'h5a5a_0000;
          r_last_o  = (b == int'(len));
          // one idle cycle between beats
          @(posedge clk);
          #2;
          r_valid_o = 1'b0;
          r_last_o  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/icache_checker.sv ====
`default_nettype none

module icache_checker (
  input wire logic        clk,
  input wire logic        rst_n,
  input wire logic        flush_i,
  input wire logic        fetch_ready_o,
  input wire logic        rsp_valid_o,
  input wire logic [31:0] rsp_instr_o,
  input wire logic        rsp_ready_i,
  input wire logic        cacop_done_o,
  input wire logic        mem_ar_valid_o,
  input wire logic        mem_ar_ready_i,
  input wire logic        mem_r_ready_o,
  input wire logic        cfg_req_i,
  input wire logic        cfg_ack_o
);

  int fail_cnt = 0;

  // pending response holds its word
  rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o && !rsp_ready_i && !flush_i |=> rsp_valid_o && $stable(rsp_instr_o))
    else begin
      fail_cnt++;
      $error("response changed while stalled");
    end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o)
    else begin
      fail_cnt++;
      $error("read address dropped before ready");
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cfg_ack_o) |-> $past(cfg_req_i))
    else begin
      fail_cnt++;
      $error("register ack without request");
    end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !(fetch_ready_o || rsp_valid_o || cacop_done_o || mem_ar_valid_o ||
                 mem_r_ready_o || cfg_ack_o))
    else begin
      fail_cnt++;
      $error("output active during reset");
    end

endmodule

bind icache_top icache_checker u_checker (.*);

`default_nettype wire

// ==== tb/tb_icache.sv ====
`default_nettype none

module tb_icache;

  localparam int WAYS = 4;
  localparam int TMO  = 200;

  logic clk, rst_n, flush, fetch_valid, rsp_ready, cacop_valid;
  logic cfg_req, cfg_we, fetch_ready, rsp_valid, cacop_ready, cacop_done;
  logic ar_valid, ar_ready, r_valid, r_last, r_ready, cfg_ack;
  logic [31:0] fetch_addr, rsp_instr, cacop_addr, ar_addr, r_data, cfg_wdata, cfg_rdata;
  logic [7:0] ar_len;
  icache_pkg::cacop_op_e cacop_op;
  icache_pkg::reg_addr_e cfg_addr;

  logic [31:0] lfsr_q = 32'ha9eb_1279;
  int err_cnt = 0;
  int hit_exp = 0;
  int miss_exp = 0;

  // last accepted fetch and the enable bit as written over the bus
  logic [31:0] last_fetch = '0;
  bit          cache_on = 1'b1;

  // reference cache contents
  bit              m_valid [16][WAYS];
  logic [23:0]     m_tag [16][WAYS];
  logic [WAYS-2:0] m_plru [16];

  icache_top #(.WAY_NUM(WAYS)) u_dut (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .fetch_valid_i(fetch_valid), .fetch_addr_i(fetch_addr), .fetch_ready_o(fetch_ready),
    .rsp_valid_o(rsp_valid), .rsp_instr_o(rsp_instr), .rsp_ready_i(rsp_ready),
    .cacop_valid_i(cacop_valid), .cacop_op_i(cacop_op), .cacop_addr_i(cacop_addr),
    .cacop_ready_o(cacop_ready), .cacop_done_o(cacop_done),
    .mem_ar_valid_o(ar_valid), .mem_ar_addr_o(ar_addr), .mem_ar_len_o(ar_len),
    .mem_ar_ready_i(ar_ready), .mem_r_valid_i(r_valid), .mem_r_data_i(r_data),
    .mem_r_last_i(r_last), .mem_r_ready_o(r_ready),
    .cfg_req_i(cfg_req), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr),
    .cfg_wdata_i(cfg_wdata), .cfg_ack_o(cfg_ack), .cfg_rdata_o(cfg_rdata)
  );

  tb_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .ar_valid_i(ar_valid), .ar_addr_i(ar_addr),
    .ar_len_i(ar_len), .ar_ready_o(ar_ready), .r_valid_o(r_valid),
    .r_data_o(r_data), .r_last_o(r_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // returns the hit way or -1
  function automatic int find_line(input logic [31:0] addr);
    icache_pkg::icache_addr_u a;
    a = addr;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[a.fetch.idx][w] && m_tag[a.fetch.idx][w] == a.fetch.tag) begin
        return w;
      end
    end
    return -1;
  endfunction

  // lookup with fill and tree update, counts the result
  function automatic void predict_access(input logic [31:0] addr);
    icache_pkg::icache_addr_u a;
    int way, node;
    a = addr;
    way = find_line(addr);
    if (way >= 0) begin
      hit_exp++;
    end else begin
      miss_exp++;
      node = 1;
      way = 0;
      // follow the tree bits down to the victim
      for (int l = 0; l < $clog2(WAYS); l++) begin
        way = 2 * way + int'(m_plru[a.fetch.idx][node-1]);
        node = 2 * node + int'(m_plru[a.fetch.idx][node-1]);
      end
      m_valid[a.fetch.idx][way] = 1'b1;
      m_tag[a.fetch.idx][way] = a.fetch.tag;
    end
    // turn every node on the path away from the used way
    node = 1;
    for (int l = $clog2(WAYS) - 1; l >= 0; l--) begin
      m_plru[a.fetch.idx][node-1] = ~way[l];
      node = 2 * node + way[l];
    end
  endfunction

  task automatic check_instr(input logic [icache_pkg::WORD_W-1:0] got,
                             input logic [icache_pkg::WORD_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s instr %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s counter %0d expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_burst(input logic [icache_pkg::ADDR_W-1:0] got_addr,
                               input logic [7:0] got_len,
                               input logic [icache_pkg::ADDR_W-1:0] exp_addr,
                               input logic [7:0] exp_len);
    if (got_addr !== exp_addr || got_len !== exp_len) begin
      $display("Fail %0t: burst %h len %0d expected %h len %0d", $time,
               got_addr, got_len, exp_addr, exp_len);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    if (fetch_valid && fetch_ready) begin
      last_fetch <= fetch_addr;
    end
  end

  // a burst fetches the line of the pending fetch, or one word when uncached
  always @(negedge clk) begin
    if (rst_n && ar_valid && ar_ready) begin
      if (cache_on) begin
        compare_burst(ar_addr, ar_len, {last_fetch[31:4], 4'h0},
                      8'(icache_pkg::LINE_WORDS - 1));
      end else begin
        compare_burst(ar_addr, ar_len, last_fetch, 8'd0);
      end
    end
    if (rst_n && r_valid && !r_ready) begin
      $display("read beat offered while the cache was not ready at %0t", $time);
      err_cnt++;
    end
  end

  task automatic timeout_fail(input string what);
    $display("timed out waiting for %s at time %0t", what, $time);
    $display("errors: %0d", err_cnt + 1);
    $display("tests failed");
    $finish;
  endtask

  task automatic wait_high(ref logic sig, input string what);
    int t;
    t = 0;
    @(negedge clk);
    while (!sig) begin
      t++;
      if (t > TMO) timeout_fail(what);
      @(negedge clk);
    end
  endtask

  task automatic fetch_and_check(input logic [31:0] addr, input bit cached);
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    wait_high(fetch_ready, "fetch ready");
    @(posedge clk);
    #2 fetch_valid = 1'b0;
    wait_high(rsp_valid, "fetch response");
    check_instr(rsp_instr, addr ^ 32'h5a5a_0000, "fetch");
    @(posedge clk);
    #2;
    if (cached) predict_access(addr);
  endtask

  task automatic cacop_do(input icache_pkg::cacop_op_e op, input logic [31:0] addr);
    int seen;
    seen = 0;
    cacop_valid = 1'b1;
    cacop_op    = op;
    cacop_addr  = addr;
    wait_high(cacop_ready, "cacop ready");
    @(posedge clk);
    #2 cacop_valid = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (cacop_done) seen++;
    end
    if (seen != 1) begin
      $display("cacop done pulsed %0d times instead of once at %0t", seen, $time);
      err_cnt++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic reg_handshake(input bit we, input icache_pkg::reg_addr_e a,
                               input logic [31:0] wd, output logic [31:0] rd);
    int t;
    cfg_req = 1'b1;
    cfg_we = we;
    cfg_addr = a;
    cfg_wdata = wd;
    wait_high(cfg_ack, "register ack");
    rd = cfg_rdata;
    @(posedge clk);
    #2 cfg_req = 1'b0;
    t = 0;
    @(negedge clk);
    while (cfg_ack) begin
      t++;
      if (t > TMO) timeout_fail("register ack release");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic cfg_write(input icache_pkg::reg_addr_e a, input logic [31:0] wd);
    logic [31:0] unused;
    reg_handshake(1'b1, a, wd, unused);
    if (a == icache_pkg::REG_CTRL) cache_on = wd[0];
  endtask

  task automatic cfg_read(input icache_pkg::reg_addr_e a, output logic [31:0] rd);
    reg_handshake(1'b0, a, '0, rd);
  endtask

  task automatic verify_counters(input string what);
    logic [31:0] v;
    cfg_read(icache_pkg::REG_HIT_CNT, v);
    check_count(v, hit_exp, {what, " hit"});
    cfg_read(icache_pkg::REG_MISS_CNT, v);
    check_count(v, miss_exp, {what, " miss"});
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic miss_then_hit();
    logic [31:0] a;
    for (int i = 0; i < 20; i++) begin
      a = {rand_bits(30), 2'b00};
      fetch_and_check(a, 1'b1);
      fetch_and_check(a, 1'b1);
    end
    verify_counters("miss then hit");
  endtask

  task automatic plru_replace();
    for (int k = 0; k < 5; k++) begin
      fetch_and_check(32'h0010_0050 + 32'(k * 32'h100), 1'b1);
    end
    fetch_and_check(32'h0010_0050, 1'b1);
    verify_counters("plru");
  endtask

  task automatic cacop_invalidate();
    logic [31:0] a, b;
    icache_pkg::icache_addr_u ia;
    int w;
    a = 32'h0020_0064;
    b = 32'h0030_0078;
    fetch_and_check(a, 1'b1);
    fetch_and_check(b, 1'b1);
    cacop_do(icache_pkg::CACOP_HIT_INV, a);
    if (find_line(a) >= 0) m_valid[6][find_line(a)] = 1'b0;
    w = find_line(b);
    ia = '0;
    ia.index.idx = 4'd7;
    ia.index.way = 4'(w);
    cacop_do(icache_pkg::CACOP_IDX_INV, ia);
    m_valid[7][w] = 1'b0;
    fetch_and_check(a, 1'b1);
    fetch_and_check(b, 1'b1);
    verify_counters("cacop");
  endtask

  task automatic disabled_fetch();
    cfg_write(icache_pkg::REG_CTRL, 32'h0);
    fetch_and_check(32'h0040_1230, 1'b0);
    fetch_and_check(32'h0030_0078, 1'b0);
    verify_counters("disabled");
    cfg_write(icache_pkg::REG_CTRL, 32'h1);
    fetch_and_check(32'h0030_0078, 1'b1);
    verify_counters("re-enabled");
  endtask

  task automatic stall_and_flush();
    logic [31:0] c;
    rsp_ready = 1'b0;
    fetch_valid = 1'b1;
    fetch_addr = 32'h0030_0078;
    wait_high(fetch_ready, "fetch ready");
    @(posedge clk);
    #2 fetch_valid = 1'b0;
    wait_high(rsp_valid, "stalled response");
    repeat (5) begin
      @(negedge clk);
      if (!rsp_valid) begin
        $display("response dropped while stalled at %0t", $time);
        err_cnt++;
      end
      check_instr(rsp_instr, 32'h0030_0078 ^ 32'h5a5a_0000, "stalled");
    end
    @(posedge clk);
    #2 rsp_ready = 1'b1;
    @(posedge clk);
    #2 predict_access(32'h0030_0078);
    // flushed refill, counted as a miss but never filled
    c = 32'h0bad_0040;
    fetch_valid = 1'b1;
    fetch_addr = c;
    wait_high(fetch_ready, "fetch ready");
    @(posedge clk);
    #2 fetch_valid = 1'b0;
    wait_high(r_ready, "refill start");
    @(posedge clk);
    #2 flush = 1'b1;
    @(posedge clk);
    #2 flush = 1'b0;
    miss_exp++;
    repeat (20) begin
      @(negedge clk);
      if (rsp_valid) begin
        $display("response seen for a flushed fetch at %0t", $time);
        err_cnt++;
      end
    end
    @(posedge clk);
    #2;
    fetch_and_check(c, 1'b1);
    verify_counters("stall and flush");
  endtask

  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    rsp_ready = 1'b1;
    cacop_valid = 1'b0;
    cacop_op = icache_pkg::CACOP_IDX_INV;
    cacop_addr = '0;
    cfg_req = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = icache_pkg::REG_CTRL;
    cfg_wdata = '0;
    for (int s = 0; s < 16; s++) begin
      m_plru[s] = '0;
      for (int w = 0; w < WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w] = '0;
      end
    end
    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    #2;
    miss_then_hit();
    plru_replace();
    cacop_invalidate();
    disabled_fetch();
    stall_and_flush();
    err_cnt += u_dut.u_checker.fail_cnt;
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/icache_pkg.sv
src/icache_sdp_ram.sv
src/icache_plru.sv
src/icache_core.sv
src/icache_ctrl_regs.sv
src/icache_top.sv
tb/tb_mem_model.sv
tb/icache_checker.sv
tb/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_sdp_ram.sv
  - src/icache_plru.sv
  - src/icache_core.sv
  - src/icache_ctrl_regs.sv
  - src/icache_top.sv
  - target: test
    files:
      - tb/tb_mem_model.sv
      - tb/icache_checker.sv
      - tb/tb_icache.sv
